/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
TOP       ?= tb_cl_hello
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* cl_hello_top.sv */
/*
  Top level of the hello-world register design.
  Connects the OCL write and read controllers to the hello/LED
  register block and the tick counter. Counter widths are set
  here and passed down.
*/

`timescale 1ns/1ps

module cl_hello_top #(
  parameter int unsigned CNT_W  = 16,
  parameter int unsigned TICK_W = 8
) (
  input  logic                 clk_main_a0,
  input  logic                 rst_main_n_sync,
  // Write address
  input  logic                 aw_valid,
  input  ocl_pkg::ocl_aw_t     aw,
  output logic                 aw_ready,
  // Write data
  input  logic                 w_valid,
  input  ocl_pkg::ocl_w_t      w,
  output logic                 w_ready,
  // Write response
  output logic                 b_valid,
  output ocl_pkg::ocl_resp_t   b_resp,
  input  logic                 b_ready,
  // Read address
  input  logic                 ar_valid,
  input  ocl_pkg::ocl_ar_t     ar,
  output logic                 ar_ready,
  // Read data
  output logic                 r_valid,
  output ocl_pkg::ocl_r_t      r,
  input  logic                 r_ready,
  // Virtual DIP and LED
  input  cl_regs_pkg::led_t    vdip,
  output cl_regs_pkg::led_t    vled
);

  import cl_regs_pkg::*;

  reg_wr_t   reg_wr;
  hello_rd_t hello_rd;
  cnt_rd_t   cnt_rd;

  // --------------------
  // Bus side
  // --------------------
  ocl_write_ctrl u_write_ctrl (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .aw_valid        (aw_valid),
    .aw              (aw),
    .aw_ready        (aw_ready),
    .w_valid         (w_valid),
    .w               (w),
    .w_ready         (w_ready),
    .b_valid         (b_valid),
    .b_resp          (b_resp),
    .b_ready         (b_ready),
    .reg_wr          (reg_wr)
  );

  ocl_read_ctrl u_read_ctrl (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .ar_valid        (ar_valid),
    .ar              (ar),
    .ar_ready        (ar_ready),
    .r_valid         (r_valid),
    .r               (r),
    .r_ready         (r_ready),
    .hello_rd        (hello_rd),
    .cnt_rd          (cnt_rd)
  );

  // --------------------
  // Register blocks
  // --------------------
  hello_regs u_hello_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .reg_wr          (reg_wr),
    .vdip            (vdip),
    .hello_rd        (hello_rd),
    .vled            (vled)
  );

  tick_counter #(
    .CNT_W  (CNT_W),
    .TICK_W (TICK_W)
  ) u_tick_counter (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .reg_wr          (reg_wr),
    .cnt_rd          (cnt_rd)
  );

endmodule

/* cl_regs_pkg.sv */
/*
  Register map of the hello-world design.
  Addresses, counter control and status bit positions, and the
  structs that carry one register write into the register blocks
  and their read values back to the read controller.
*/

package cl_regs_pkg;

  // --------------------
  // Address map
  // --------------------
  localparam ocl_pkg::ocl_addr_t HELLO_WORLD_ADDR = 32'h0000_0500;
  localparam ocl_pkg::ocl_addr_t VLED_ADDR        = 32'h0000_0504;
  localparam ocl_pkg::ocl_addr_t CNT_CTRL_ADDR    = 32'h0000_0600;
  localparam ocl_pkg::ocl_addr_t TICK_VALUE_ADDR  = 32'h0000_0604;
  localparam ocl_pkg::ocl_addr_t LOAD_VALUE_ADDR  = 32'h0000_0608;
  localparam ocl_pkg::ocl_addr_t WATERMARK_ADDR   = 32'h0000_060C;
  localparam ocl_pkg::ocl_addr_t CNT_VALUE_ADDR   = 32'h0000_0610;
  localparam ocl_pkg::ocl_addr_t CNT_STATUS_ADDR  = 32'h0000_0614;

  // CNT_CTRL fields; clear and load are self-clearing pulses
  localparam int unsigned CTRL_ENABLE_BIT  = 0;
  localparam int unsigned CTRL_CLEAR_BIT   = 1;
  localparam int unsigned CTRL_LOAD_BIT    = 2;
  localparam int unsigned CTRL_ONESHOT_BIT = 3;

  // CNT_STATUS fields
  localparam int unsigned STATUS_WMARK_BIT     = 0;
  localparam int unsigned STATUS_TICK_BIT      = 1;
  localparam int unsigned STATUS_TICK_CNT_LSB  = 16;
  localparam int unsigned STATUS_TICK_CNT_W    = 16;

  // --------------------
  // Value types
  // --------------------
  localparam int unsigned LED_W = 16;
  typedef logic [LED_W-1:0] led_t;

  // One register write, enable high for a single cycle
  typedef struct packed {
    logic                en;
    ocl_pkg::ocl_addr_t  addr;
    ocl_pkg::ocl_data_t  data;
  } reg_wr_t;

  // Hello block read values
  typedef struct packed {
    ocl_pkg::ocl_data_t  hello_swapped;
    led_t                led_shadow;
  } hello_rd_t;

  // Counter block read values, widened to bus words
  typedef struct packed {
    ocl_pkg::ocl_data_t  count;
    ocl_pkg::ocl_data_t  tick_cnt;
    logic                ge_watermark;
    logic                tick;
  } cnt_rd_t;

endpackage

/* hello_regs.sv */
/*
  Hello-world register and virtual LED path.
  The hello word reads back byte-swapped. Its low half is shadowed
  into the LED register, masked by the synchronized DIP switches
  and registered out to the LED pins.
*/

`timescale 1ns/1ps

module hello_regs (
  input  logic                   clk_main_a0,
  input  logic                   rst_main_n_sync,
  input  cl_regs_pkg::reg_wr_t   reg_wr,
  input  cl_regs_pkg::led_t      vdip,
  output cl_regs_pkg::hello_rd_t hello_rd,
  output cl_regs_pkg::led_t      vled
);

  import ocl_pkg::*;
  import cl_regs_pkg::*;

  ocl_data_t hello_q;
  led_t      led_shadow_q;
  led_t      vdip_q1;
  led_t      vdip_q2;

  // --------------------
  // Hello-world register
  // --------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      hello_q <= '0;
    end
    else if (reg_wr.en && (reg_wr.addr == HELLO_WORLD_ADDR))
    begin
      hello_q <= reg_wr.data;
    end
  end

  // Byte order reversed on readback
  assign hello_rd.hello_swapped = {hello_q[7:0], hello_q[15:8],
                                   hello_q[23:16], hello_q[31:24]};
  assign hello_rd.led_shadow    = led_shadow_q;

  // --------------------
  // Virtual LED path
  // --------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      led_shadow_q <= '0;
      vdip_q1      <= '0;
      vdip_q2      <= '0;
      vled         <= '0;
    end
    else
    begin
      // Shadow trails the hello word by one edge
      led_shadow_q <= hello_q[LED_W-1:0];
      // Two-flop DIP synchronizer
      vdip_q1      <= vdip;
      vdip_q2      <= vdip_q1;
      // Masked and registered LED drive
      vled         <= led_shadow_q & vdip_q2;
    end
  end

endmodule

/* ocl_pkg.sv */
/*
  AXI-Lite OCL bus definitions shared by the register port.
  Holds the channel payload structs, the bus widths and the
  response codes. Ports and internal nets take these types so
  every block agrees on the layout of an address or data beat.
*/

package ocl_pkg;

  // --------------------
  // Bus widths
  // --------------------
  localparam int unsigned OCL_ADDR_W = 32;
  localparam int unsigned OCL_DATA_W = 32;

  // Byte address and data word on the bus
  typedef logic [OCL_ADDR_W-1:0] ocl_addr_t;
  typedef logic [OCL_DATA_W-1:0] ocl_data_t;

  // Response code, only OKAY is ever returned
  typedef logic [1:0] ocl_resp_t;
  localparam ocl_resp_t OCL_RESP_OKAY = 2'b00;

  // --------------------
  // Channel payloads
  // --------------------
  // Write address beat
  typedef struct packed {
    ocl_addr_t addr;
  } ocl_aw_t;

  // Write data beat, strobes not carried
  typedef struct packed {
    ocl_data_t data;
  } ocl_w_t;

  // Read address beat
  typedef struct packed {
    ocl_addr_t addr;
  } ocl_ar_t;

  // Read data beat with its response
  typedef struct packed {
    ocl_data_t data;
    ocl_resp_t resp;
  } ocl_r_t;

endpackage

/* ocl_read_ctrl.sv */
/*
  AXI-Lite read side of the OCL port.
  Registers one read address, decodes it against the register map
  on the next cycle and holds the response until it is accepted.
  Unmapped addresses read as zero with an OKAY response.
*/

`timescale 1ns/1ps

module ocl_read_ctrl (
  input  logic                   clk_main_a0,
  input  logic                   rst_main_n_sync,
  // Read address
  input  logic                   ar_valid,
  input  ocl_pkg::ocl_ar_t       ar,
  output logic                   ar_ready,
  // Read data
  output logic                   r_valid,
  output ocl_pkg::ocl_r_t        r,
  input  logic                   r_ready,
  // Register block values
  input  cl_regs_pkg::hello_rd_t hello_rd,
  input  cl_regs_pkg::cnt_rd_t   cnt_rd
);

  import ocl_pkg::*;
  import cl_regs_pkg::*;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ADDR,
    RD_RESP
  } rd_state_e;

  rd_state_e rd_state;
  ocl_addr_t rd_addr_q;
  ocl_data_t rd_data;
  ocl_data_t status_word;

  assign ar_ready = (rd_state == RD_IDLE);
  assign r_valid  = (rd_state == RD_RESP);

  // --------------------
  // Read FSM
  // --------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      rd_state <= RD_IDLE;
    end
    else
    begin
      case (rd_state)
        RD_IDLE: if (ar_valid) rd_state <= RD_ADDR;
        RD_ADDR: rd_state <= RD_RESP;
        RD_RESP: if (r_ready)  rd_state <= RD_IDLE;
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_main_a0)
  begin
    if (ar_valid && ar_ready)
      rd_addr_q <= ar.addr;
  end

  // Counter status word
  always_comb
  begin
    status_word = '0;
    status_word[STATUS_WMARK_BIT] = cnt_rd.ge_watermark;
    status_word[STATUS_TICK_BIT]  = cnt_rd.tick;
    status_word[STATUS_TICK_CNT_LSB +: STATUS_TICK_CNT_W] =
      cnt_rd.tick_cnt[STATUS_TICK_CNT_W-1:0];
  end

  // Address decode, zero for anything unmapped
  always_comb
  begin
    case (rd_addr_q)
      HELLO_WORLD_ADDR: rd_data = hello_rd.hello_swapped;
      VLED_ADDR:        rd_data = ocl_data_t'(hello_rd.led_shadow);
      CNT_VALUE_ADDR:   rd_data = cnt_rd.count;
      CNT_STATUS_ADDR:  rd_data = status_word;
      default:          rd_data = '0;
    endcase
  end

  // Response payload, stable while waiting on r_ready
  always_ff @(posedge clk_main_a0)
  begin
    if (rd_state == RD_ADDR)
    begin
      r.data <= rd_data;
      r.resp <= OCL_RESP_OKAY;
    end
  end

endmodule

/* ocl_write_ctrl.sv */
/*
  AXI-Lite write side of the OCL port.
  Takes one address beat, then one data beat, and turns the pair
  into a single-cycle register write strobe. The response is held
  until accepted, and no new address is taken before that.
*/

`timescale 1ns/1ps

module ocl_write_ctrl (
  input  logic                 clk_main_a0,
  input  logic                 rst_main_n_sync,
  // Write address
  input  logic                 aw_valid,
  input  ocl_pkg::ocl_aw_t     aw,
  output logic                 aw_ready,
  // Write data
  input  logic                 w_valid,
  input  ocl_pkg::ocl_w_t      w,
  output logic                 w_ready,
  // Write response
  output logic                 b_valid,
  output ocl_pkg::ocl_resp_t   b_resp,
  input  logic                 b_ready,
  // Register write strobe
  output cl_regs_pkg::reg_wr_t reg_wr
);

  import ocl_pkg::*;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_e;

  wr_state_e wr_state;
  ocl_addr_t wr_addr_q;

  // Handshake outputs straight from state
  assign aw_ready = (wr_state == WR_IDLE);
  assign w_ready  = (wr_state == WR_DATA) && w_valid;
  assign b_valid  = (wr_state == WR_RESP);
  assign b_resp   = OCL_RESP_OKAY;

  // --------------------
  // Write FSM
  // --------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      wr_state <= WR_IDLE;
    end
    else
    begin
      case (wr_state)
        WR_IDLE: if (aw_valid) wr_state <= WR_DATA;
        WR_DATA: if (w_valid)  wr_state <= WR_RESP;
        WR_RESP: if (b_ready)  wr_state <= WR_IDLE;
        default: wr_state <= WR_IDLE;
      endcase
    end
  end

  // Address held for the data beat
  always_ff @(posedge clk_main_a0)
  begin
    if (aw_valid && aw_ready)
    begin
      wr_addr_q <= aw.addr;
    end
  end

  // Strobe only on the data handshake cycle
  // full-word write, strobes are not on this port
  assign reg_wr.en   = w_ready;
  assign reg_wr.addr = wr_addr_q;
  assign reg_wr.data = w.data;

endmodule

/* sim.f */
ocl_pkg.sv
cl_regs_pkg.sv
ocl_write_ctrl.sv
hello_regs.sv
tick_counter.sv
ocl_read_ctrl.sv
cl_hello_top.sv
tb_cl_hello.sv

/* tb_cl_hello.sv */
/*
  Testbench for the hello-world register design.
  Runs a table of bus writes, reads, DIP settings, waits and LED checks
  against cl_hello_top over the OCL AXI-Lite port, with random valid
  gaps and random b_ready / r_ready stalls on every transaction.
*/

`timescale 1ns/1ps

module tb_cl_hello;

  import ocl_pkg::*;
  import cl_regs_pkg::*;

  localparam int        WAIT_LIMIT = 50;
  localparam ocl_data_t FULL       = 32'hFFFF_FFFF;
  localparam ocl_data_t CTRL_EN    = ocl_data_t'(1) << CTRL_ENABLE_BIT;
  localparam ocl_data_t CTRL_CLR   = ocl_data_t'(1) << CTRL_CLEAR_BIT;
  localparam ocl_data_t CTRL_LD    = ocl_data_t'(1) << CTRL_LOAD_BIT;
  localparam ocl_data_t CTRL_OS    = ocl_data_t'(1) << CTRL_ONESHOT_BIT;

  // Table operations
  typedef enum logic [2:0] {
    OP_WR,
    OP_RD,
    OP_RD_LT,
    OP_DIP,
    OP_WAIT,
    OP_LED
  } op_e;

  // One table entry; data is the write value, DIP value or cycle count
  typedef struct packed {
    op_e       op;
    ocl_addr_t addr;
    ocl_data_t data;
    ocl_data_t mask;
    ocl_data_t exp;
  } step_t;

  logic       clk_main_a0;
  logic       rst_main_n_sync;
  logic       aw_valid;
  ocl_aw_t    aw;
  logic       aw_ready;
  logic       w_valid;
  ocl_w_t     w;
  logic       w_ready;
  logic       b_valid;
  ocl_resp_t  b_resp;
  logic       b_ready;
  logic       ar_valid;
  ocl_ar_t    ar;
  logic       ar_ready;
  logic       r_valid;
  ocl_r_t     r;
  logic       r_ready;
  led_t       vdip;
  led_t       vled;

  step_t       steps[$];
  int          data_errs;
  int          proto_errs;

  cl_hello_top #(
    .CNT_W  (16),
    .TICK_W (8)
  ) u_dut (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .aw_valid        (aw_valid),
    .aw              (aw),
    .aw_ready        (aw_ready),
    .w_valid         (w_valid),
    .w               (w),
    .w_ready         (w_ready),
    .b_valid         (b_valid),
    .b_resp          (b_resp),
    .b_ready         (b_ready),
    .ar_valid        (ar_valid),
    .ar              (ar),
    .ar_ready        (ar_ready),
    .r_valid         (r_valid),
    .r               (r),
    .r_ready         (r_ready),
    .vdip            (vdip),
    .vled            (vled)
  );

  // 8 ns clock
  initial
  begin
    clk_main_a0 = 1'b0;
    forever #4 clk_main_a0 = ~clk_main_a0;
  end

  // --------------------
  // Bus helpers
  // --------------------
  task automatic abort_run(input string what);
    $display("ERROR: timeout, %s", what);
    $display("FAIL: see errors above");
    $finish;
  endtask

  task automatic write_reg(input ocl_addr_t addr, input ocl_data_t data);
    int unsigned gap;
    int unsigned stall;
    int          cnt;
    logic        hs;
    // Address beat after a random gap
    gap = $urandom_range(0, 3);
    repeat (gap) @(negedge clk_main_a0);
    aw_valid = 1'b1;
    aw.addr  = addr;
    cnt = 0;
    hs  = 1'b0;
    while (!hs)
    begin
      @(posedge clk_main_a0);
      hs  = aw_ready;
      cnt = cnt + 1;
      if (!hs && cnt > WAIT_LIMIT)
        abort_run("aw_ready never rose");
    end
    @(negedge clk_main_a0);
    aw_valid = 1'b0;
    aw       = '0;
    // Data beat
    gap = $urandom_range(0, 3);
    repeat (gap) @(negedge clk_main_a0);
    w_valid = 1'b1;
    w.data  = data;
    cnt = 0;
    hs  = 1'b0;
    while (!hs)
    begin
      @(posedge clk_main_a0);
      hs  = w_ready;
      cnt = cnt + 1;
      if (!hs && cnt > WAIT_LIMIT)
        abort_run("w_ready never rose");
    end
    @(negedge clk_main_a0);
    w_valid = 1'b0;
    w       = '0;
    // Response wait
    cnt = 0;
    while (!b_valid)
    begin
      @(negedge clk_main_a0);
      cnt = cnt + 1;
      if (!b_valid && cnt > WAIT_LIMIT)
        abort_run("b_valid never rose");
    end
    if (b_resp !== OCL_RESP_OKAY)
    begin
      $display("FAIL b_resp: got %h expected %h", b_resp, OCL_RESP_OKAY);
      data_errs = data_errs + 1;
    end
    // b_valid must hold through the stall
    stall = $urandom_range(0, 5);
    repeat (stall)
    begin
      @(negedge clk_main_a0);
      if (b_valid !== 1'b1)
      begin
        $display("FAIL b_valid: got %h expected 1 during stall", b_valid);
        proto_errs = proto_errs + 1;
      end
    end
    // b_valid is high, so the next edge completes it
    b_ready = 1'b1;
    @(posedge clk_main_a0);
    @(negedge clk_main_a0);
    b_ready = 1'b0;
  endtask

  task automatic read_reg(input ocl_addr_t addr, output ocl_data_t data);
    int unsigned gap;
    int unsigned stall;
    int          cnt;
    logic        hs;
    ocl_r_t      held;
    gap = $urandom_range(0, 3);
    repeat (gap) @(negedge clk_main_a0);
    ar_valid = 1'b1;
    ar.addr  = addr;
    cnt = 0;
    hs  = 1'b0;
    while (!hs)
    begin
      @(posedge clk_main_a0);
      hs  = ar_ready;
      cnt = cnt + 1;
      if (!hs && cnt > WAIT_LIMIT)
        abort_run("ar_ready never rose");
    end
    @(negedge clk_main_a0);
    ar_valid = 1'b0;
    ar       = '0;
    cnt = 0;
    while (!r_valid)
    begin
      @(negedge clk_main_a0);
      cnt = cnt + 1;
      if (!r_valid && cnt > WAIT_LIMIT)
        abort_run("r_valid never rose");
    end
    held = r;
    if (held.resp !== OCL_RESP_OKAY)
    begin
      $display("FAIL r.resp @%h: got %h expected %h", addr, held.resp, OCL_RESP_OKAY);
      data_errs = data_errs + 1;
    end
    // Payload frozen while r_ready is low
    stall = $urandom_range(0, 5);
    repeat (stall)
    begin
      @(negedge clk_main_a0);
      if (r_valid !== 1'b1 || r !== held)
      begin
        $display("FAIL r: got valid %h data %h expected valid 1 data %h during stall",
                 r_valid, r.data, held.data);
        proto_errs = proto_errs + 1;
      end
    end
    r_ready = 1'b1;
    @(posedge clk_main_a0);
    @(negedge clk_main_a0);
    r_ready = 1'b0;
    data    = held.data;
  endtask

  // --------------------
  // Stimulus table
  // --------------------
  task automatic add_step(input op_e op, input ocl_addr_t addr, input ocl_data_t data,
                          input ocl_data_t mask, input ocl_data_t exp);
    step_t s;
    s.op   = op;
    s.addr = addr;
    s.data = data;
    s.mask = mask;
    s.exp  = exp;
    steps.push_back(s);
  endtask

  task automatic build_table();
    // Byte swap on readback
    add_step(OP_WR, HELLO_WORLD_ADDR, 32'h1234_5678, '0, '0);
    add_step(OP_RD, HELLO_WORLD_ADDR, '0, FULL, 32'h7856_3412);
    add_step(OP_WR, HELLO_WORLD_ADDR, 32'hCAFE_F00D, '0, '0);
    add_step(OP_RD, HELLO_WORLD_ADDR, '0, FULL, 32'h0DF0_FECA);
    // LED shadow, then DIP mask on the pins
    add_step(OP_RD, VLED_ADDR, '0, FULL, 32'h0000_F00D);
    add_step(OP_DIP, '0, 32'h0000_00FF, '0, '0);
    add_step(OP_WAIT, '0, 32'd8, '0, '0);
    add_step(OP_LED, '0, '0, '0, 32'h0000_000D);
    add_step(OP_DIP, '0, 32'h0000_FFFF, '0, '0);
    add_step(OP_WAIT, '0, 32'd8, '0, '0);
    add_step(OP_LED, '0, '0, '0, 32'h0000_F00D);
    // Load with counter idle, watermark, clear
    add_step(OP_WR, CNT_CTRL_ADDR, 32'h0, '0, '0);
    add_step(OP_WR, LOAD_VALUE_ADDR, 32'h0000_0123, '0, '0);
    add_step(OP_WR, CNT_CTRL_ADDR, CTRL_LD, '0, '0);
    add_step(OP_RD, CNT_VALUE_ADDR, '0, FULL, 32'h0000_0123);
    add_step(OP_WR, WATERMARK_ADDR, 32'h0000_0100, '0, '0);
    add_step(OP_RD, CNT_STATUS_ADDR, '0, 32'h1, 32'h1);
    add_step(OP_WR, CNT_CTRL_ADDR, CTRL_CLR, '0, '0);
    add_step(OP_RD, CNT_VALUE_ADDR, '0, FULL, 32'h0);
    add_step(OP_RD, CNT_STATUS_ADDR, '0, 32'h1, 32'h0);
    // Oneshot stops at the top
    add_step(OP_WR, TICK_VALUE_ADDR, 32'h0, '0, '0);
    add_step(OP_WR, LOAD_VALUE_ADDR, 32'h0000_FFFE, '0, '0);
    add_step(OP_WR, CNT_CTRL_ADDR, CTRL_OS | CTRL_LD, '0, '0);
    add_step(OP_WR, CNT_CTRL_ADDR, CTRL_OS | CTRL_EN, '0, '0);
    add_step(OP_WAIT, '0, 32'd20, '0, '0);
    add_step(OP_RD, CNT_VALUE_ADDR, '0, FULL, 32'h0000_FFFF);
    // Without oneshot it rolls over
    add_step(OP_WR, CNT_CTRL_ADDR, 32'h0, '0, '0);
    add_step(OP_WR, LOAD_VALUE_ADDR, 32'h0000_FFF0, '0, '0);
    add_step(OP_WR, CNT_CTRL_ADDR, CTRL_LD, '0, '0);
    add_step(OP_RD, CNT_VALUE_ADDR, '0, FULL, 32'h0000_FFF0);
    add_step(OP_WR, CNT_CTRL_ADDR, CTRL_EN, '0, '0);
    add_step(OP_WAIT, '0, 32'd40, '0, '0);
    add_step(OP_WR, CNT_CTRL_ADDR, 32'h0, '0, '0);
    add_step(OP_RD_LT, CNT_VALUE_ADDR, '0, FULL, 32'h0000_0100);
    // Unmapped reads as zero, then a normal read still works
    add_step(OP_RD, 32'h0000_0700, '0, FULL, 32'h0);
    add_step(OP_RD, HELLO_WORLD_ADDR, '0, FULL, 32'h0DF0_FECA);
  endtask

  task automatic run_step(input step_t s);
    ocl_data_t rdata;
    case (s.op)
      OP_WR: write_reg(s.addr, s.data);
      OP_RD:
      begin
        read_reg(s.addr, rdata);
        if ((rdata & s.mask) !== s.exp)
        begin
          $display("FAIL r.data @%h: got %h expected %h", s.addr, rdata & s.mask, s.exp);
          data_errs = data_errs + 1;
        end
      end
      OP_RD_LT:
      begin
        read_reg(s.addr, rdata);
        if (rdata >= s.exp)
        begin
          $display("FAIL r.data @%h: got %h expected below %h", s.addr, rdata, s.exp);
          data_errs = data_errs + 1;
        end
      end
      OP_DIP:  vdip = s.data[LED_W-1:0];
      OP_WAIT: repeat (s.data) @(negedge clk_main_a0);
      OP_LED:
      begin
        if (vled !== s.exp[LED_W-1:0])
        begin
          $display("FAIL vled: got %h expected %h", vled, s.exp[LED_W-1:0]);
          data_errs = data_errs + 1;
        end
      end
      default: ;
    endcase
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial
  begin
    rst_main_n_sync = 1'b0;
    aw_valid        = 1'b0;
    aw              = '0;
    w_valid         = 1'b0;
    w               = '0;
    b_ready         = 1'b0;
    ar_valid        = 1'b0;
    ar              = '0;
    r_ready         = 1'b0;
    vdip            = '0;
    data_errs       = 0;
    proto_errs      = 0;
    void'($urandom(32'h9cae_ecee));
    build_table();
    // Two cycles of reset, released on a falling edge
    repeat (2) @(posedge clk_main_a0);
    @(negedge clk_main_a0);
    rst_main_n_sync = 1'b1;
    @(negedge clk_main_a0);
    foreach (steps[i])
      run_step(steps[i]);
    repeat (4) @(negedge clk_main_a0);
    $display("Run done: %0d data errors, %0d protocol errors", data_errs, proto_errs);
    if (data_errs == 0 && proto_errs == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* tick_counter.sv */
/*
  Tick prescaler and event counter, controlled over the register port.
  The prescaler divides the clock by tick value + 1 while enabled, and
  each tick advances the count. Clear and load are one-cycle pulses,
  oneshot makes the count stop at its maximum instead of wrapping.
*/

`timescale 1ns/1ps

module tick_counter #(
  parameter int unsigned CNT_W  = 16,
  parameter int unsigned TICK_W = 8
) (
  input  logic                 clk_main_a0,
  input  logic                 rst_main_n_sync,
  input  cl_regs_pkg::reg_wr_t reg_wr,
  output cl_regs_pkg::cnt_rd_t cnt_rd
);

  import ocl_pkg::*;
  import cl_regs_pkg::*;

  localparam logic [CNT_W-1:0] CNT_MAX = '1;

  // Control register state
  logic              enable_q;
  logic              oneshot_q;
  logic              clear_pulse;
  logic              load_pulse;
  logic [TICK_W-1:0] tick_value_q;
  logic [CNT_W-1:0]  load_value_q;
  logic [CNT_W-1:0]  watermark_q;

  // Counters
  logic [TICK_W-1:0] tick_cnt;
  logic [CNT_W-1:0]  count;
  logic              tick;

  // --------------------
  // Register decode
  // --------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      enable_q     <= 1'b0;
      oneshot_q    <= 1'b0;
      clear_pulse  <= 1'b0;
      load_pulse   <= 1'b0;
      tick_value_q <= '0;
      load_value_q <= '0;
      watermark_q  <= '0;
    end
    else
    begin
      // Pulses drop after one cycle unless rewritten
      clear_pulse <= 1'b0;
      load_pulse  <= 1'b0;
      if (reg_wr.en)
      begin
        case (reg_wr.addr)
          CNT_CTRL_ADDR:
          begin
            enable_q    <= reg_wr.data[CTRL_ENABLE_BIT];
            oneshot_q   <= reg_wr.data[CTRL_ONESHOT_BIT];
            clear_pulse <= reg_wr.data[CTRL_CLEAR_BIT];
            load_pulse  <= reg_wr.data[CTRL_LOAD_BIT];
          end
          TICK_VALUE_ADDR: tick_value_q <= reg_wr.data[TICK_W-1:0];
          LOAD_VALUE_ADDR: load_value_q <= reg_wr.data[CNT_W-1:0];
          WATERMARK_ADDR:  watermark_q  <= reg_wr.data[CNT_W-1:0];
          default: ;
        endcase
      end
    end
  end

  // Prescaler terminal count
  assign tick = (tick_cnt >= tick_value_q);

  // --------------------
  // Prescaler and counter
  // --------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync || clear_pulse)
    begin
      tick_cnt <= '0;
      count    <= '0;
    end
    else
    begin
      // Load beats enable, the prescaler keeps running
      if (enable_q)
      begin
        tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
      end
      if (load_pulse)
      begin
        count <= load_value_q;
      end
      else if (enable_q && tick)
      begin
        if (count != CNT_MAX)
          count <= count + 1'b1;
        else if (!oneshot_q)
          count <= '0;
      end
    end
  end

  // Status, widened to bus words
  assign cnt_rd.count        = ocl_data_t'(count);
  assign cnt_rd.tick_cnt     = ocl_data_t'(tick_cnt);
  assign cnt_rd.ge_watermark = (count >= watermark_q);
  assign cnt_rd.tick         = tick;

endmodule
